// ==== logic/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  rv_exec_pkg::alu_ctrl_e         i_ctrl,
    input  logic [rv_exec_pkg::XLEN-1:0]   i_a,
    input  logic [rv_exec_pkg::XLEN-1:0]   i_b,
    output logic [rv_exec_pkg::XLEN-1:0]   o_result,
    output logic                           o_zero
);
    import rv_exec_pkg::*;

    logic [$clog2(XLEN)-1:0] shamt;
    logic                    lt_signed;
    logic                    lt_unsigned;

    assign shamt       = i_b[$clog2(XLEN)-1:0];
    assign lt_signed   = $signed(i_a) < $signed(i_b);
    assign lt_unsigned = i_a < i_b;

    always_comb begin
        case (i_ctrl)
            ALU_ADD: begin
                o_result = i_a + i_b;
            end
            ALU_SUB: begin
                o_result = i_a - i_b;
            end
            ALU_SLL: begin
                o_result = i_a << shamt;
            end
            ALU_SLT: begin
                o_result = {{(XLEN-1){1'b0}}, lt_signed};
            end
            ALU_SLTU: begin
                o_result = {{(XLEN-1){1'b0}}, lt_unsigned};
            end
            ALU_XOR: begin
                o_result = i_a ^ i_b;
            end
            ALU_SRL: begin
                o_result = i_a >> shamt;
            end
            ALU_SRA: begin
                o_result = $signed(i_a) >>> shamt;  // sign bit fills from the left
            end
            ALU_OR: begin
                o_result = i_a | i_b;
            end
            ALU_AND: begin
                o_result = i_a & i_b;
            end
            default: begin
                o_result = '0;
            end
        endcase
    end

    // branch logic reads this after a SUB
    assign o_zero = (o_result == '0);

endmodule

// ==== logic/alu_control.sv ====
`timescale 1ns/1ps

module alu_control (
    input  rv_exec_pkg::alu_class_e i_alu_class,
    input  logic [2:0]              i_funct3,
    input  logic [6:0]              i_funct7,
    output rv_exec_pkg::alu_ctrl_e  o_alu_ctrl,
    output logic                    o_illegal
);
    import rv_exec_pkg::*;

    alu_ctrl_e f3_ctrl;

    // operation chosen by funct3 alone, common to R-type and I-type
    always_comb begin
        case (i_funct3)
            3'b000:  f3_ctrl = ALU_ADD;
            3'b001:  f3_ctrl = ALU_SLL;
            3'b010:  f3_ctrl = ALU_SLT;
            3'b011:  f3_ctrl = ALU_SLTU;
            3'b100:  f3_ctrl = ALU_XOR;
            3'b101:  f3_ctrl = ALU_SRL;
            3'b110:  f3_ctrl = ALU_OR;
            default: f3_ctrl = ALU_AND;
        endcase
    end

    always_comb begin
        o_alu_ctrl = ALU_ADD;  // illegal cases fall back to ADD
        o_illegal  = 1'b0;

        case (i_alu_class)
            ALUOP_MEM: begin
                o_alu_ctrl = ALU_ADD;
            end
            ALUOP_U: begin
                o_alu_ctrl = ALU_ADD;
            end
            ALUOP_B: begin
                case (i_funct3)
                    3'b000, 3'b001: o_alu_ctrl = ALU_SUB;   // beq and bne look at zero
                    3'b100, 3'b101: o_alu_ctrl = ALU_SLT;
                    3'b110, 3'b111: o_alu_ctrl = ALU_SLTU;
                    default:        o_illegal  = 1'b1;
                endcase
            end
            ALUOP_R: begin
                if (i_funct7 == F7_BASE) begin
                    o_alu_ctrl = f3_ctrl;
                end else if (i_funct7 == F7_ALT && i_funct3 == 3'b000) begin
                    o_alu_ctrl = ALU_SUB;
                end else if (i_funct7 == F7_ALT && i_funct3 == 3'b101) begin
                    o_alu_ctrl = ALU_SRA;
                end else begin
                    o_illegal = 1'b1;
                end
            end
            ALUOP_I: begin
                // only shifts right read the upper immediate bits
                if (i_funct3 != 3'b101) begin
                    o_alu_ctrl = f3_ctrl;
                end else if (i_funct7 == F7_BASE) begin
                    o_alu_ctrl = ALU_SRL;
                end else if (i_funct7 == F7_ALT) begin
                    o_alu_ctrl = ALU_SRA;
                end else begin
                    o_illegal = 1'b1;
                end
            end
            default: begin
                o_illegal = 1'b1;
            end
        endcase
    end

endmodule

// ==== logic/alu_stage.sv ====
`timescale 1ns/1ps

module alu_stage (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_valid,
    input  rv_exec_pkg::exec_req_t i_req,
    output logic                   o_valid,
    output rv_exec_pkg::exec_res_t o_res
);
    import rv_exec_pkg::*;

    alu_ctrl_e       alu_ctrl;
    logic            ctrl_illegal;
    logic [XLEN-1:0] alu_result;
    logic            alu_zero;

    alu_control u_alu_control (
        .i_alu_class (i_req.alu_class),
        .i_funct3    (i_req.funct3),
        .i_funct7    (i_req.funct7),
        .o_alu_ctrl  (alu_ctrl),
        .o_illegal   (ctrl_illegal)
    );

    alu u_alu (
        .i_ctrl   (alu_ctrl),
        .i_a      (i_req.op_a),
        .i_b      (i_req.op_b),
        .o_result (alu_result),
        .o_zero   (alu_zero)
    );

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_res.result  <= alu_result;
            o_res.zero    <= alu_zero;
            o_res.illegal <= i_req.illegal | ctrl_illegal;  // decode or funct problem
        end
    end

endmodule

// ==== logic/exec_pipe.sv ====
`timescale 1ns/1ps

module exec_pipe #(
    parameter int PIPE_DEPTH = 2
) (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_valid,
    input  rv_exec_pkg::exec_req_t i_req,
    output logic                   o_valid,
    output rv_exec_pkg::exec_req_t o_req
);
    import rv_exec_pkg::*;

    logic [PIPE_DEPTH-1:0] stage_valid;
    exec_req_t             stage_req [PIPE_DEPTH];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            stage_valid <= '0;
        end else begin
            stage_valid[0] <= i_valid;
            for (int i = 1; i < PIPE_DEPTH; i++) begin
                stage_valid[i] <= stage_valid[i-1];
            end
        end
    end

    // requests shift every cycle so several can be in flight at once
    always_ff @(posedge i_clk) begin
        stage_req[0] <= i_req;
        for (int i = 1; i < PIPE_DEPTH; i++) begin
            stage_req[i] <= stage_req[i-1];
        end
    end

    assign o_valid = stage_valid[PIPE_DEPTH-1];
    assign o_req   = stage_req[PIPE_DEPTH-1];

endmodule

// ==== logic/exec_top.sv ====
`timescale 1ns/1ps

module exec_top #(
    parameter int PIPE_DEPTH = 2
) (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  logic                         i_valid,
    input  logic [31:0]                  i_instr,
    input  logic [rv_exec_pkg::XLEN-1:0] i_rs1_val,
    input  logic [rv_exec_pkg::XLEN-1:0] i_rs2_val,
    input  logic [rv_exec_pkg::XLEN-1:0] i_pc,
    output logic                         o_valid,
    output rv_exec_pkg::exec_res_t       o_res
);
    import rv_exec_pkg::*;

    logic      dec_valid;
    exec_req_t dec_req;
    logic      pipe_valid;
    exec_req_t pipe_req;

    instr_decoder u_decoder (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_valid   (i_valid),
        .i_instr   (i_instr),
        .i_rs1_val (i_rs1_val),
        .i_rs2_val (i_rs2_val),
        .i_pc      (i_pc),
        .o_valid   (dec_valid),
        .o_req     (dec_req)
    );

    exec_pipe #(
        .PIPE_DEPTH (PIPE_DEPTH)
    ) u_pipe (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (dec_valid),
        .i_req   (dec_req),
        .o_valid (pipe_valid),
        .o_req   (pipe_req)
    );

    alu_stage u_stage (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (pipe_valid),
        .i_req   (pipe_req),
        .o_valid (o_valid),
        .o_res   (o_res)
    );

endmodule

// ==== logic/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    input  logic                             i_valid,
    input  logic [31:0]                      i_instr,
    input  logic [rv_exec_pkg::XLEN-1:0]     i_rs1_val,
    input  logic [rv_exec_pkg::XLEN-1:0]     i_rs2_val,
    input  logic [rv_exec_pkg::XLEN-1:0]     i_pc,
    output logic                             o_valid,
    output rv_exec_pkg::exec_req_t           o_req
);
    import rv_exec_pkg::*;

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_u;
    exec_req_t       req_d;

    assign imm_i = {{(XLEN-12){i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{(XLEN-12){i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_u = {i_instr[31:12], {(XLEN-20){1'b0}}};

    always_comb begin
        req_d.alu_class = ALUOP_MEM;
        req_d.funct3    = i_instr[14:12];
        req_d.funct7    = i_instr[31:25];
        req_d.op_a      = i_rs1_val;
        req_d.op_b      = i_rs2_val;
        req_d.illegal   = 1'b0;

        case (i_instr[6:0])
            OP_R: begin
                req_d.alu_class = ALUOP_R;
            end
            OP_I: begin
                req_d.alu_class = ALUOP_I;
                req_d.op_b      = imm_i;
            end
            OP_LOAD: begin
                req_d.op_b = imm_i;  // address add
            end
            OP_STORE: begin
                req_d.op_b = imm_s;
            end
            OP_BRANCH: begin
                req_d.alu_class = ALUOP_B;  // compare value of rs1 against rs2
            end
            OP_LUI: begin
                req_d.alu_class = ALUOP_U;
                req_d.op_a      = '0;
                req_d.op_b      = imm_u;
            end
            OP_AUIPC: begin
                req_d.alu_class = ALUOP_U;
                req_d.op_a      = i_pc;
                req_d.op_b      = imm_u;
            end
            default: begin
                // unknown opcode gives a zero result flagged illegal
                req_d.op_a    = '0;
                req_d.op_b    = '0;
                req_d.illegal = 1'b1;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_req <= req_d;  // payload only moves on a strobe
        end
    end

endmodule

// ==== logic/rv_exec_pkg.sv ====
package rv_exec_pkg;

    parameter int XLEN = 32;

    // major opcodes handled by the execute path
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_I      = 7'b0010011,
        OP_AUIPC  = 7'b0010111,
        OP_STORE  = 7'b0100011,
        OP_R      = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011
    } opcode_e;

    // operation class handed from decode to the ALU control
    typedef enum logic [2:0] {
        ALUOP_MEM = 3'b000,
        ALUOP_B   = 3'b001,
        ALUOP_R   = 3'b010,
        ALUOP_I   = 3'b011,
        ALUOP_U   = 3'b100
    } alu_class_e;

    // ALU control lines
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_ctrl_e;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // selects SUB and SRA/SRAI

    // request travelling from decode to execute
    typedef struct packed {
        alu_class_e      alu_class;
        logic [2:0]      funct3;
        logic [6:0]      funct7;   // for I-type this is imm[11:5], so SRAI shows up as F7_ALT
        logic [XLEN-1:0] op_a;
        logic [XLEN-1:0] op_b;
        logic            illegal;  // opcode not known to the decoder
    } exec_req_t;

    // registered execute result
    typedef struct packed {
        logic [XLEN-1:0] result;
        logic            zero;
        logic            illegal;
    } exec_res_t;

endpackage

// ==== project.f ====
logic/rv_exec_pkg.sv
logic/instr_decoder.sv
logic/exec_pipe.sv
logic/alu_control.sv
logic/alu.sv
logic/alu_stage.sv
logic/exec_top.sv
tb/exec_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile with Verilator, run the testbench and look for the pass line in its output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module exec_tb -f project.f -o exec_sim \
    && ./obj_dir/exec_sim | tee /dev/stderr | grep -qx "Test OK" \
    && { echo "run.sh: simulation passed"; exit 0; } \
    || { echo "run.sh: simulation did not pass"; exit 1; }

// ==== tb/exec_tb.sv ====
`timescale 1ns/1ps

module exec_tb;
    import rv_exec_pkg::*;

    localparam int PIPE_DEPTH = 2;
    localparam int MAX_TESTS  = 64;

    logic            i_clk;
    logic            i_rst_n   = 1'b0;
    logic            i_valid   = 1'b0;
    logic [31:0]     i_instr   = '0;
    logic [XLEN-1:0] i_rs1_val = '0;
    logic [XLEN-1:0] i_rs2_val = '0;
    logic [XLEN-1:0] i_pc      = '0;
    logic            o_valid;
    exec_res_t       o_res;

    string           t_name   [MAX_TESTS];
    logic [31:0]     t_instr  [MAX_TESTS];
    logic [31:0]     t_rs1    [MAX_TESTS];
    logic [31:0]     t_rs2    [MAX_TESTS];
    logic [31:0]     t_pc     [MAX_TESTS];
    logic [31:0]     t_result [MAX_TESTS];
    logic            t_ill    [MAX_TESTS];
    int              due_cycle [MAX_TESTS];
    int              pending[$];  // test indices in flight with the oldest at the front
    int              n_tests = 0;
    int              errors  = 0;
    int              checked = 0;
    int              cycle   = 0;
    int              limit   = 0;
    int              gap;
    int              idx;

    exec_top #(
        .PIPE_DEPTH (PIPE_DEPTH)
    ) dut_i (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_valid   (i_valid),
        .i_instr   (i_instr),
        .i_rs1_val (i_rs1_val),
        .i_rs2_val (i_rs2_val),
        .i_pc      (i_pc),
        .o_valid   (o_valid),
        .o_res     (o_res)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    always @(posedge i_clk) cycle <= cycle + 1;

    always @(negedge i_clk) begin
        if (cycle > limit) begin
            $display("timeout after %0d cycles with %0d results outstanding",
                     cycle, pending.size());
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic load_trace();
        int           fd;
        int           n;
        string        line;
        string        name;
        logic [31:0]  f_instr, f_rs1, f_rs2, f_pc, f_res, f_ill;
        fd = $fopen("tb/exec_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file tb/exec_trace.txt");
            return;
        end
        while (!$feof(fd) && n_tests < MAX_TESTS) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%s %h %h %h %h %h %h", name, f_instr, f_rs1, f_rs2,
                            f_pc, f_res, f_ill);
                if (n == 7) begin
                    t_name[n_tests]   = name;
                    t_instr[n_tests]  = f_instr;
                    t_rs1[n_tests]    = f_rs1;
                    t_rs2[n_tests]    = f_rs2;
                    t_pc[n_tests]     = f_pc;
                    t_result[n_tests] = f_res;
                    t_ill[n_tests]    = f_ill[0];
                    n_tests++;
                end else begin
                    $display("trace line could not be parsed: %s", line);
                    errors++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic send_test(input int t);
        i_valid   <= 1'b1;
        i_instr   <= t_instr[t];
        i_rs1_val <= t_rs1[t];
        i_rs2_val <= t_rs2[t];
        i_pc      <= t_pc[t];
        due_cycle[t] = cycle + PIPE_DEPTH + 3;  // cycle counter moves on at this same edge
        pending.push_back(t);
    endtask

    // each output is matched against the oldest request in flight
    always @(negedge i_clk) begin
        if (o_valid === 1'b1) begin
            if (pending.size() == 0) begin
                $display("output at cycle %0d with no request in flight", cycle);
                errors++;
            end else begin
                idx = pending.pop_front();
                checked++;
                if (cycle != due_cycle[idx]) begin
                    $display("output for %0s came at cycle %0d but was due at cycle %0d",
                             t_name[idx], cycle, due_cycle[idx]);
                    errors++;
                end
                if (o_res.result !== t_result[idx]) begin
                    $display("CHECK FAILED %0s result expected %h actual %h",
                             t_name[idx], t_result[idx], o_res.result);
                    errors++;
                end
                if (o_res.illegal !== t_ill[idx]) begin
                    $display("CHECK FAILED %0s illegal expected %b actual %b",
                             t_name[idx], t_ill[idx], o_res.illegal);
                    errors++;
                end
                if (o_res.zero !== (t_result[idx] == 32'd0)) begin
                    $display("CHECK FAILED %0s zero expected %b actual %b",
                             t_name[idx], (t_result[idx] == 32'd0), o_res.zero);
                    errors++;
                end
            end
        end else if (o_valid !== 1'b0) begin
            $display("o_valid is neither high nor low at cycle %0d", cycle);
            errors++;
        end else if (pending.size() != 0 && cycle >= due_cycle[pending[0]]) begin
            $display("no output for %0s at cycle %0d", t_name[pending[0]], cycle);
            void'(pending.pop_front());
            errors++;
        end
    end

    initial begin
        void'($urandom(24611));
        load_trace();
        limit = n_tests * 3 + PIPE_DEPTH + 40;
        repeat (8) @(posedge i_clk);
        i_rst_n <= 1'b1;
        if (n_tests == 0) begin
            $display("no tests were read from the trace file");
            errors++;
        end else begin
            for (int t = 0; t < n_tests; t++) begin
                gap = (t < 4) ? 0 : int'($urandom % 3);  // first strobes go back to back
                repeat (gap) begin
                    @(posedge i_clk);
                    i_valid <= 1'b0;
                end
                @(posedge i_clk);
                send_test(t);
            end
            @(posedge i_clk);
            i_valid <= 1'b0;
            while (pending.size() != 0) @(posedge i_clk);
            repeat (PIPE_DEPTH + 4) @(posedge i_clk);  // catch stray outputs after the last one
        end
        $display("tests %0d, checked %0d, errors %0d", n_tests, checked, errors);
        if (errors == 0 && checked == n_tests) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== tb/exec_trace.txt ====
# name instr rs1 rs2 pc expected_result expected_illegal, all values in hex
# zero is expected high exactly when expected_result is 0
add        002081B3 00000005 00000007 00000000 0000000C 0
sub        402081B3 00000005 00000007 00000000 FFFFFFFE 0
sll        002091B3 00000001 00000024 00000000 00000010 0
slt        0020A1B3 FFFFFFFF 00000001 00000000 00000001 0
sltu       0020B1B3 FFFFFFFF 00000001 00000000 00000000 0
xor        0020C1B3 F0F0F0F0 0FF00FF0 00000000 FF00FF00 0
srl        0020D1B3 80000000 00000004 00000000 08000000 0
sra        4020D1B3 80000000 00000004 00000000 F8000000 0
or         0020E1B3 12340000 00005678 00000000 12345678 0
and        0020F1B3 FF00FF00 0F0F0F0F 00000000 0F000F00 0
r_alt_and  4020F1B3 00000001 00000002 00000000 00000003 1
r_f7_one   022081B3 0000000A 00000014 00000000 0000001E 1
addi_neg   FFF08193 00000010 DEADBEEF 00000000 0000000F 0
slti       FFF0A193 FFFFFFFE DEADBEEF 00000000 00000001 0
sltiu      FFF0B193 00000005 DEADBEEF 00000000 00000001 0
xori       FFF0C193 12345678 DEADBEEF 00000000 EDCBA987 0
ori        0F00E193 00000F00 DEADBEEF 00000000 00000FF0 0
andi       0FF0F193 12345678 DEADBEEF 00000000 00000078 0
slli       00309193 00000011 DEADBEEF 00000000 00000088 0
srli       0080D193 F0000000 DEADBEEF 00000000 00F00000 0
srai       4080D193 F0000000 DEADBEEF 00000000 FFF00000 0
lui        123451B7 11111111 22222222 00000400 12345000 0
auipc      00010197 11111111 22222222 00000400 00010400 0
auipc_neg  FFFFF197 11111111 22222222 00002000 00001000 0
lw         FFC0A183 00001000 22222222 00000000 00000FFC 0
sw_neg     FE20AC23 00002000 55555555 00000000 00001FF8 0
sw_pos     0020AA23 00000100 55555555 00000000 00000114 0
beq        00208063 00000042 00000042 00000000 00000000 0
bne        00209063 00000005 00000003 00000000 00000002 0
blt        0020C063 FFFFFFF0 00000001 00000000 00000001 0
bge        0020D063 00000001 FFFFFFF0 00000000 00000000 0
bltu       0020E063 FFFFFFF0 00000001 00000000 00000000 0
bgeu       0020F063 00000001 FFFFFFF0 00000000 00000001 0
br_f3_two  0020A063 00000001 00000002 00000000 00000003 1
unknown_op 0000000F 00000000 00000000 00000000 00000000 1
